//--- rtl/BlockRam.sv
/*
 * Single-port array with registered read, payload set by type
 */
`default_nettype none

module BlockRam #(
    parameter type DataType = logic [31:0],
    parameter int INDEX_WIDTH = 4
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic [INDEX_WIDTH-1:0] index,
    input wire logic writeEnable,
    input wire DataType writeValue,
    output DataType readValue
);
    DataType array [2**INDEX_WIDTH];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            array[index] <= writeValue;
        end
    end

    // Read returns the old entry on a same-cycle write
    always_ff @(posedge clk) begin
        if (rst) begin
            readValue <= '0;
        end else begin
            readValue <= array[index];
        end
    end
endmodule

`default_nettype wire

//--- rtl/FetchCreditGate.sv
/*
 * Decode credit counter and registered instruction output
 */
`default_nettype none
`include "fetch_defines.svh"

module FetchCreditGate import FetchTypes::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic hitValid,
    input wire addr_t hitPc,
    input wire insn_t hitInsn,
    input wire logic creditReturn,
    output logic accept,
    output logic outValid,
    output addr_t outPc,
    output insn_t outInsn
);
    localparam int CREDIT_WIDTH = $clog2(`FETCH_CREDITS + 1);

    logic [CREDIT_WIDTH-1:0] creditCount;

    assign accept = hitValid && (creditCount != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            creditCount <= CREDIT_WIDTH'(`FETCH_CREDITS);
            outValid <= 1'b0;
        end else begin
            // Take and return in the same cycle cancel out
            unique case ({accept, creditReturn})
                2'b10: creditCount <= creditCount - 1'b1;
                2'b01: creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
            outValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outPc <= hitPc;
            outInsn <= hitInsn;
        end
    end
endmodule

`default_nettype wire

//--- rtl/FetchTypes.sv
/*
 * Address, instruction, cache line, tag and index types
 * Tag array entry and cache core states
 */
`default_nettype none
`include "fetch_defines.svh"

package FetchTypes;
    // Byte offset within a line
    localparam int OFFSET_WIDTH = $clog2(`FETCH_LINE_WORDS) + 2;
    localparam int TAG_WIDTH = 32 - `FETCH_INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] insn_t;
    typedef insn_t [`FETCH_LINE_WORDS-1:0] line_t;
    typedef logic [`FETCH_INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [31-OFFSET_WIDTH:0] lineAddr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } TagEntry;

    typedef enum logic [1:0] {
        Lookup,
        Refill,
        Invalidate
    } CoreState;
endpackage

`default_nettype wire

//--- rtl/FetchUnit.sv
/*
 * Fetch stage top: PC generator, cache core and credit gate
 */
`default_nettype none

module FetchUnit import FetchTypes::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic redirectValid,
    input wire addr_t redirectPc,
    input wire logic invalidateReq,
    input wire logic creditReturn,
    output logic memReadReq,
    output lineAddr_t memAddr,
    input wire logic memReadGrant,
    input wire line_t memReadValue,
    output logic outValid,
    output addr_t outPc,
    output insn_t outInsn
);
    addr_t fetchPc;
    logic fetchReq;
    logic redirecting;
    logic accept;

    logic hitValid;
    addr_t hitPc;
    insn_t hitInsn;

    PcGenerator pcGen (
        .clk,
        .rst,
        .redirectValid,
        .redirectPc,
        .accept,
        .fetchPc,
        .fetchReq,
        .redirecting
    );

    ICacheCore cacheCore (
        .clk,
        .rst,
        .fetchPc,
        .fetchReq,
        .redirecting,
        .invalidateReq,
        .accept,
        .memReadGrant,
        .memReadValue,
        .memReadReq,
        .memAddr,
        .hitValid,
        .hitPc,
        .hitInsn
    );

    FetchCreditGate creditGate (
        .clk,
        .rst,
        .hitValid,
        .hitPc,
        .hitInsn,
        .creditReturn,
        .accept,
        .outValid,
        .outPc,
        .outInsn
    );
endmodule

`default_nettype wire

//--- rtl/ICacheCore.sv
/*
 * Direct-mapped instruction cache: tag/data arrays, two-stage lookup,
 * miss handling through the replacer and invalidate sweep
 */
`default_nettype none

module ICacheCore import FetchTypes::*; (
    input wire logic clk,
    input wire logic rst,
    input wire addr_t fetchPc,
    input wire logic fetchReq,
    input wire logic redirecting,
    input wire logic invalidateReq,
    input wire logic accept,
    input wire logic memReadGrant,
    input wire line_t memReadValue,
    output logic memReadReq,
    output lineAddr_t memAddr,
    output logic hitValid,
    output addr_t hitPc,
    output insn_t hitInsn
);
    CoreState state;
    CoreState nextState;
    logic invalidatePending;
    logic sweepStart;
    index_t sweepIndex;

    // Lookup stage 2
    logic stage2Valid;
    addr_t stage2Pc;
    logic tagMatch;
    logic miss;
    index_t lookupIndex;

    index_t tagIndex;
    logic tagWriteEnable;
    TagEntry tagWriteValue;
    TagEntry tagReadValue;
    index_t dataIndex;
    logic dataWriteEnable;
    line_t dataReadValue;

    logic refillStart;
    lineAddr_t refillAddr;
    logic refillDone;
    logic replacerWriteEnable;
    index_t replacerIndex;
    tag_t replacerTag;
    line_t replacerData;

    BlockRam #(
        .DataType(TagEntry),
        .INDEX_WIDTH($bits(index_t))
    ) tagArray (
        .clk,
        .rst,
        .index(tagIndex),
        .writeEnable(tagWriteEnable),
        .writeValue(tagWriteValue),
        .readValue(tagReadValue)
    );

    BlockRam #(
        .DataType(line_t),
        .INDEX_WIDTH($bits(index_t))
    ) dataArray (
        .clk,
        .rst,
        .index(dataIndex),
        .writeEnable(dataWriteEnable),
        .writeValue(replacerData),
        .readValue(dataReadValue)
    );

    ICacheReplacer replacer (
        .clk,
        .rst,
        .refillStart,
        .refillAddr,
        .memReadGrant,
        .memReadValue,
        .memReadReq,
        .memAddr,
        .arrayWriteEnable(replacerWriteEnable),
        .arrayIndex(replacerIndex),
        .arrayWriteTag(replacerTag),
        .arrayWriteData(replacerData),
        .refillDone
    );

    assign lookupIndex = fetchPc[OFFSET_WIDTH +: $bits(index_t)];

    // Stage 2 compare and word select
    always_comb begin
        tagMatch = tagReadValue.valid &&
            (tagReadValue.tag == stage2Pc[31 -: $bits(tag_t)]);
        hitValid = stage2Valid && tagMatch && !redirecting;
        miss = stage2Valid && !tagMatch && !redirecting;
        hitPc = stage2Pc;
        hitInsn = dataReadValue[stage2Pc[OFFSET_WIDTH-1:2]];
    end

    always_comb begin
        nextState = state;
        unique case (state)
            Lookup: begin
                if (invalidatePending) begin
                    nextState = Invalidate;
                end else if (miss) begin
                    nextState = Refill;
                end
            end
            Refill: begin
                if (refillDone) begin
                    nextState = invalidatePending ? Invalidate : Lookup;
                end
            end
            Invalidate: begin
                if (sweepIndex == '1) begin
                    nextState = Lookup;
                end
            end
            default: begin
                nextState = Invalidate;
            end
        endcase
    end

    assign refillStart = (state == Lookup) && (nextState == Refill);
    assign refillAddr = stage2Pc[31:OFFSET_WIDTH];
    assign sweepStart = (state != Invalidate) && (nextState == Invalidate);

    // Array port owner follows the core state
    always_comb begin
        unique case (state)
            Refill: begin
                tagIndex = replacerIndex;
                tagWriteEnable = replacerWriteEnable;
                tagWriteValue = '{valid: 1'b1, tag: replacerTag};
            end
            Invalidate: begin
                tagIndex = sweepIndex;
                tagWriteEnable = 1'b1;
                tagWriteValue = '0;
            end
            default: begin
                tagIndex = lookupIndex;
                tagWriteEnable = 1'b0;
                tagWriteValue = '0;
            end
        endcase
        dataIndex = (state == Refill) ? replacerIndex : lookupIndex;
        dataWriteEnable = (state == Refill) && replacerWriteEnable;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Invalidate;
            sweepIndex <= '0;
            invalidatePending <= 1'b0;
            stage2Valid <= 1'b0;
        end else begin
            state <= nextState;
            sweepIndex <= (state == Invalidate) ? sweepIndex + 1'b1 : '0;
            invalidatePending <= invalidateReq || (invalidatePending && !sweepStart);
            // An unaccepted hit is looked up again from the same PC
            stage2Valid <= (state == Lookup) && (nextState == Lookup) &&
                fetchReq && !redirecting;
        end
    end

    always_ff @(posedge clk) begin
        stage2Pc <= fetchPc;
    end
endmodule

`default_nettype wire

//--- rtl/ICacheReplacer.sv
/*
 * Line refill engine: one memory read, then a tag and data write
 */
`default_nettype none

module ICacheReplacer import FetchTypes::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic refillStart,
    input wire lineAddr_t refillAddr,
    input wire logic memReadGrant,
    input wire line_t memReadValue,
    output logic memReadReq,
    output lineAddr_t memAddr,
    output logic arrayWriteEnable,
    output index_t arrayIndex,
    output tag_t arrayWriteTag,
    output line_t arrayWriteData,
    output logic refillDone
);
    typedef enum logic [1:0] {
        Idle,
        Request,
        Write
    } ReplacerState;

    ReplacerState state;
    lineAddr_t missAddr;
    line_t lineBuffer;

    // Request held with a stable address until the grant
    assign memReadReq = (state == Request);
    assign memAddr = missAddr;

    assign arrayWriteEnable = (state == Write);
    assign arrayIndex = missAddr[$bits(index_t)-1:0];
    assign arrayWriteTag = missAddr[$bits(lineAddr_t)-1 -: $bits(tag_t)];
    assign arrayWriteData = lineBuffer;
    assign refillDone = (state == Write);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            unique case (state)
                Idle: begin
                    if (refillStart) begin
                        state <= Request;
                    end
                end
                Request: begin
                    if (memReadGrant) begin
                        state <= Write;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && refillStart) begin
            missAddr <= refillAddr;
        end
        if (state == Request && memReadGrant) begin
            lineBuffer <= memReadValue;
        end
    end
endmodule

`default_nettype wire

//--- rtl/PcGenerator.sv
/*
 * Program counter with redirect load and post-redirect stall
 */
`default_nettype none
`include "fetch_defines.svh"

module PcGenerator import FetchTypes::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic redirectValid,
    input wire addr_t redirectPc,
    input wire logic accept,
    output addr_t fetchPc,
    output logic fetchReq,
    output logic redirecting
);
    localparam int STALL_WIDTH = $clog2(`FETCH_FLUSH_STALL + 1);

    // PC of the instruction sitting in the lookup stage
    addr_t pc;
    logic [STALL_WIDTH-1:0] stallCount;

    // Address presented to the cache this cycle
    always_comb begin
        if (redirectValid) begin
            fetchPc = redirectPc;
        end else if (accept) begin
            fetchPc = pc + 32'd4;
        end else begin
            fetchPc = pc;
        end
    end

    assign fetchReq = (stallCount == '0);
    assign redirecting = redirectValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FETCH_INITIAL_PC;
            stallCount <= STALL_WIDTH'(`FETCH_FLUSH_STALL);
        end else begin
            pc <= fetchPc;
            if (redirectValid) begin
                stallCount <= STALL_WIDTH'(`FETCH_FLUSH_STALL);
            end else if (stallCount != '0) begin
                stallCount <= stallCount - 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

//--- rtl/fetch_defines.svh
/*
 * Fetch stage sizing, credit count and reset values
 */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Cache geometry, 16 lines of 4 instructions
`define FETCH_INDEX_WIDTH 4
`define FETCH_LINE_WORDS 4

// Decode credits after reset
`define FETCH_CREDITS 4

// Reset PC
`define FETCH_INITIAL_PC 32'h0000_1000

// Idle cycles after a redirect
`define FETCH_FLUSH_STALL 2

`endif

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module FetchUnitTb -f src.f

output=$(./obj_dir/VFetchUnitTb)
echo "$output"

if grep -qx "Test completed successfully" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- src.f
+incdir+rtl
rtl/FetchTypes.sv
rtl/BlockRam.sv
rtl/PcGenerator.sv
rtl/ICacheReplacer.sv
rtl/ICacheCore.sv
rtl/FetchCreditGate.sv
rtl/FetchUnit.sv
test/ClockGen.sv
test/FetchUnitTb.sv

//--- test/ClockGen.sv
/*
 * Testbench clock and power-on reset
 */
`default_nettype none

module ClockGen #(
    parameter int PERIOD = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end
endmodule

`default_nettype wire

//--- test/FetchUnitTb.sv
/*
 * Fetch stage testbench with memory and decode models,
 * scenarios from the input file, value checks and a watchdog
 */
`default_nettype none
`include "fetch_defines.svh"

module FetchUnitTb import FetchTypes::*; ();
    localparam insn_t INSN_KEY = 32'hA5A5_0000;
    localparam int CYCLES_PER_SCENARIO = 200;

    logic clk;
    logic rst;
    logic redirectValid;
    addr_t redirectPc;
    logic invalidateReq;
    logic creditReturn;
    logic memReadReq;
    lineAddr_t memAddr;
    logic memReadGrant;
    line_t memReadValue;
    logic outValid;
    addr_t outPc;
    insn_t outInsn;

    // Decode side record and credit bookkeeping
    addr_t pcQ[$];
    insn_t insnQ[$];
    lineAddr_t reqQ[$];
    int unsigned dueQ[$];
    bit withhold;
    int heldCredits;

    string opList[$];
    addr_t targetList[$];
    int countList[$];
    int reqList[$];
    insn_t firstList[$];
    bit loaded;

    int checkCount;
    int errorCount;

    ClockGen #(.PERIOD(4), .RESET_CYCLES(5)) clockGen (.clk, .rst);

    FetchUnit dut (
        .clk,
        .rst,
        .redirectValid,
        .redirectPc,
        .invalidateReq,
        .creditReturn,
        .memReadReq,
        .memAddr,
        .memReadGrant,
        .memReadValue,
        .outValid,
        .outPc,
        .outInsn
    );

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        checkCount++;
        assert (expected === actual) else begin
            errorCount++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic bit lineInRange(lineAddr_t la, addr_t first, int count);
        addr_t base;
        addr_t last;
        base = {la, {OFFSET_WIDTH{1'b0}}};
        last = first + addr_t'(count * 4) - 1;
        return (base + addr_t'(`FETCH_LINE_WORDS * 4) - 1 >= first) && (base <= last);
    endfunction

    task automatic loadScenarios();
        int fd;
        string text;
        string op;
        addr_t target;
        int count;
        int reqs;
        insn_t first;
        fd = $fopen("test/fetch_input.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the scenario file test/fetch_input.txt");
        end else begin
            while ($fgets(text, fd) > 0) begin
                if (text.len() > 0 && text.getc(0) != 8'h23) begin
                    if ($sscanf(text, "%s %h %d %d %h", op, target, count, reqs, first) == 5) begin
                        opList.push_back(op);
                        targetList.push_back(target);
                        countList.push_back(count);
                        reqList.push_back(reqs);
                        firstList.push_back(first);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    // Outputs sampled in the redirect cycle still belong to the old path
    task automatic startRedirect(addr_t target);
        redirectValid <= 1'b1;
        redirectPc <= target;
        reqQ.delete();
        @(posedge clk);
        redirectValid <= 1'b0;
        pcQ.delete();
        insnQ.delete();
    endtask

    task automatic waitOutputs(int count);
        while (pcQ.size() < count) begin
            @(posedge clk);
        end
    endtask

    task automatic checkRun(string name, addr_t target, int count, int expReq, insn_t expFirst);
        int inRange;
        addr_t expPc;
        inRange = 0;
        checkValue({name, " first pc"}, target, pcQ[0]);
        checkValue({name, " first insn"}, expFirst, insnQ[0]);
        for (int i = 0; i < count; i++) begin
            expPc = target + addr_t'(i * 4);
            checkValue($sformatf("%s pc[%0d]", name, i), expPc, pcQ[i]);
            checkValue($sformatf("%s insn[%0d]", name, i), expPc ^ INSN_KEY, insnQ[i]);
        end
        foreach (reqQ[j]) begin
            if (lineInRange(reqQ[j], target, count)) begin
                inRange++;
            end
        end
        checkValue({name, " memory requests"}, expReq, inRange);
    endtask

    task automatic runScenario(int idx);
        string name;
        name = $sformatf("%s@%h", opList[idx], targetList[idx]);
        if (opList[idx] == "invalidate") begin
            invalidateReq <= 1'b1;
            @(posedge clk);
            invalidateReq <= 1'b0;
            startRedirect(targetList[idx]);
        end else if (opList[idx] == "stall-credits") begin
            heldCredits = 0;
            withhold = 1'b1;
            startRedirect(targetList[idx]);
            repeat (40) @(posedge clk);
            checkCount++;
            assert (heldCredits <= `FETCH_CREDITS) else begin
                errorCount++;
                $display("%s: %0d outputs seen while credits were withheld", name, heldCredits);
            end
            withhold = 1'b0;
            repeat (heldCredits) dueQ.push_back(0);
        end else begin
            startRedirect(targetList[idx]);
        end
        waitOutputs(countList[idx]);
        checkRun(name, targetList[idx], countList[idx], reqList[idx], firstList[idx]);
    endtask

    // Memory with 1 to 6 cycles of latency
    initial begin
        int unsigned latency;
        addr_t base;
        line_t line;
        int w;
        memReadGrant = 1'b0;
        memReadValue = '0;
        forever begin
            @(negedge clk);
            if (rst == 1'b0 && memReadReq) begin
                reqQ.push_back(memAddr);
                base = {memAddr, {OFFSET_WIDTH{1'b0}}};
                for (w = 0; w < `FETCH_LINE_WORDS; w++) begin
                    line[w] = (base + addr_t'(w * 4)) ^ INSN_KEY;
                end
                latency = $urandom_range(6, 1);
                repeat (latency) @(posedge clk);
                memReadGrant <= 1'b1;
                memReadValue <= line;
                @(posedge clk);
                memReadGrant <= 1'b0;
            end
        end
    end

    // Decode side capture
    always @(negedge clk) begin
        if (rst == 1'b0 && outValid) begin
            pcQ.push_back(outPc);
            insnQ.push_back(outInsn);
            if (withhold) begin
                heldCredits++;
            end else begin
                dueQ.push_back($urandom_range(3, 0));
            end
        end
    end

    // One credit back per cycle in order of use
    always @(posedge clk) begin
        creditReturn <= 1'b0;
        foreach (dueQ[i]) begin
            if (dueQ[i] != 0) begin
                dueQ[i] = dueQ[i] - 1;
            end
        end
        if (dueQ.size() > 0 && dueQ[0] == 0) begin
            creditReturn <= 1'b1;
            void'(dueQ.pop_front());
        end
    end

    initial begin
        wait (loaded);
        repeat ((opList.size() + 1) * CYCLES_PER_SCENARIO) @(posedge clk);
        $display("Watchdog expired before all scenarios finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        redirectValid = 1'b0;
        redirectPc = '0;
        invalidateReq = 1'b0;
        creditReturn = 1'b0;
        withhold = 1'b0;
        heldCredits = 0;
        checkCount = 0;
        errorCount = 0;
        loaded = 1'b0;
        void'($urandom(32'hb31b));
        loadScenarios();
        wait (rst == 1'b0);
        @(posedge clk);
        // Sequential run of two lines from the reset PC
        waitOutputs(8);
        checkRun("reset", `FETCH_INITIAL_PC, 8, 2, `FETCH_INITIAL_PC ^ INSN_KEY);
        foreach (opList[i]) begin
            runScenario(i);
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- test/fetch_input.txt
# op target_pc insn_count expected_mem_requests expected_first_insn
# target, first insn in hex; count and requests in decimal
redirect 00002000 12 3 a5a52000
redirect 00002000 12 0 a5a52000
redirect 00002408 6 2 a5a52408
invalidate 00002000 12 3 a5a52000
stall-credits 00003004 16 5 a5a53004
redirect 00003004 16 0 a5a53004
redirect 00001ffc 3 2 a5a51ffc
